// ==== logic/display_pkg.sv ====
/*
 * Shared pixel-path definitions for the palette display pipeline.
 * Holds the YUV colour layout, the palette index type and the default
 * sixteen-colour set that the palette loads at reset.
 */

package display_pkg;

    localparam int Y_BITS = 4;
    localparam int U_BITS = 3;
    localparam int V_BITS = 3;
    localparam int INDEX_BITS = 4;
    localparam int PALETTE_SIZE = 16;

    // Y sits in the upper bits, followed by U and then V.
    typedef struct packed {
        logic [Y_BITS-1:0] y;
        logic [U_BITS-1:0] u;
        logic [V_BITS-1:0] v;
    } color_t;

    typedef logic [INDEX_BITS-1:0] palette_index_t;

    // Mid-scale chroma with zero luma reads as black on the display.
    localparam color_t VOID_COLOR = 10'b0000_011_011;

    localparam color_t DEFAULT_PALETTE [PALETTE_SIZE] = '{
        VOID_COLOR,
        10'b1001_100_100,   // grey
        10'b1111_011_011,   // white
        10'b0101_011_110,   // red
        10'b1001_011_101,   // pink
        10'b0011_011_100,   // dark brown
        10'b0110_010_101,   // brown
        10'b1001_010_101,   // orange
        10'b1101_010_100,   // yellow
        10'b0100_100_011,   // dark green
        10'b0110_010_011,   // green
        10'b1010_001_011,   // light green
        10'b0010_100_011,   // night blue
        10'b0100_101_010,   // sea blue
        10'b1000_101_010,   // sky blue
        10'b1101_100_011    // cloud blue
    };

endpackage

// ==== logic/command_pkg.sv ====
/*
 * Command port encoding for the display pipeline.
 * Used by the command decoder and by the testbench to build commands.
 */

package command_pkg;

    localparam int CMD_OPCODE_BITS = 3;
    localparam int CMD_DATA_BITS = 16;

    // Codes outside this list are treated as a no-op by the decoder.
    typedef enum logic [CMD_OPCODE_BITS-1:0] {
        CMD_NOP        = 3'd0,
        CMD_SET_COLOR  = 3'd1,
        CMD_SET_PIXEL  = 3'd2,
        CMD_SCAN_START = 3'd3,
        CMD_SCAN_STOP  = 3'd4
    } cmd_opcode_e;

    // Field positions of CMD_SET_COLOR.
    localparam int COLOR_INDEX_MSB = 13;
    localparam int COLOR_INDEX_LSB = 10;
    localparam int COLOR_VALUE_MSB = 9;
    localparam int COLOR_VALUE_LSB = 0;

    // Field positions of CMD_SET_PIXEL.
    localparam int PIXEL_ADDRESS_MSB = 15;
    localparam int PIXEL_ADDRESS_LSB = 4;
    localparam int PIXEL_INDEX_MSB = 3;
    localparam int PIXEL_INDEX_LSB = 0;

endpackage

// ==== logic/display_write_if.sv ====
/*
 * Write strobes and fields from the command decoder to the storage blocks.
 * The decoder drives everything; the palette and the frame buffer each
 * see only their own strobe and fields.
 */

`timescale 1ns/1ps

interface display_write_if #(
    parameter int FRAME_WIDTH = 16,
    parameter int FRAME_HEIGHT = 16
);

    localparam int PIXEL_COUNT = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int ADDRESS_BITS = (PIXEL_COUNT > 1) ? $clog2(PIXEL_COUNT) : 1;

    logic palette_write;
    display_pkg::palette_index_t palette_index;
    display_pkg::color_t palette_color;

    logic pixel_write;
    logic [ADDRESS_BITS-1:0] pixel_address;
    display_pkg::palette_index_t pixel_index;

    modport decoder (
        output palette_write, palette_index, palette_color,
        output pixel_write, pixel_address, pixel_index
    );

    modport palette (input palette_write, palette_index, palette_color);

    modport buffer (input pixel_write, pixel_address, pixel_index);

endinterface

// ==== logic/command_decoder.sv ====
/*
 * Four-phase req/ack command port.
 * Each accepted command becomes a one-cycle write strobe on the write bus
 * or a change of the scan enable level, in the cycle cmd_ack rises.
 */

`timescale 1ns/1ps

module command_decoder #(
    parameter int FRAME_WIDTH = 16,
    parameter int FRAME_HEIGHT = 16
) (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic cmd_req,
    input  command_pkg::cmd_opcode_e cmd_opcode,
    input  logic [command_pkg::CMD_DATA_BITS-1:0] cmd_data,
    output logic cmd_ack,
    output logic scan_enable,
    display_write_if.decoder writes
);

    localparam int PIXEL_COUNT = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int ADDRESS_BITS = (PIXEL_COUNT > 1) ? $clog2(PIXEL_COUNT) : 1;
    localparam int FIELD_BITS =
        command_pkg::PIXEL_ADDRESS_MSB - command_pkg::PIXEL_ADDRESS_LSB + 1;

    // One spare bit so that a full 4096-pixel frame still compares correctly.
    localparam logic [FIELD_BITS:0] PIXEL_LIMIT = (FIELD_BITS + 1)'(PIXEL_COUNT);

    typedef enum logic {
        DECODE_WAIT_REQ,
        DECODE_WAIT_RELEASE
    } decode_state_e;

    decode_state_e state;
    logic [FIELD_BITS-1:0] address_field;
    logic address_in_range;

    assign address_field = cmd_data[command_pkg::PIXEL_ADDRESS_MSB:command_pkg::PIXEL_ADDRESS_LSB];
    assign address_in_range = {1'b0, address_field} < PIXEL_LIMIT;

    // The acknowledge is simply the registered handshake state.
    assign cmd_ack = (state == DECODE_WAIT_RELEASE);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= DECODE_WAIT_REQ;
            scan_enable <= 1'b0;
            writes.palette_write <= 1'b0;
            writes.pixel_write <= 1'b0;
        end else begin
            // Strobes last one cycle unless a new command sets them again.
            writes.palette_write <= 1'b0;
            writes.pixel_write <= 1'b0;

            case (state)
                DECODE_WAIT_REQ: begin
                    if (cmd_req) begin
                        state <= DECODE_WAIT_RELEASE;

                        case (cmd_opcode)
                            command_pkg::CMD_SET_COLOR: begin
                                writes.palette_write <= 1'b1;
                            end
                            command_pkg::CMD_SET_PIXEL: begin
                                // Out-of-frame addresses are acknowledged but dropped.
                                writes.pixel_write <= address_in_range;
                            end
                            command_pkg::CMD_SCAN_START: begin
                                scan_enable <= 1'b1;
                            end
                            command_pkg::CMD_SCAN_STOP: begin
                                scan_enable <= 1'b0;
                            end
                            default: begin
                            end
                        endcase
                    end
                end

                DECODE_WAIT_RELEASE: begin
                    if (!cmd_req) begin
                        state <= DECODE_WAIT_REQ;
                    end
                end

                default: begin
                    state <= DECODE_WAIT_REQ;
                end
            endcase
        end
    end

    // The fields are only looked at while their strobe is high.
    always_ff @(posedge clock_in) begin
        if (state == DECODE_WAIT_REQ && cmd_req) begin
            writes.palette_index <=
                cmd_data[command_pkg::COLOR_INDEX_MSB:command_pkg::COLOR_INDEX_LSB];
            writes.palette_color <=
                cmd_data[command_pkg::COLOR_VALUE_MSB:command_pkg::COLOR_VALUE_LSB];
            writes.pixel_address <= address_field[ADDRESS_BITS-1:0];
            writes.pixel_index <=
                cmd_data[command_pkg::PIXEL_INDEX_MSB:command_pkg::PIXEL_INDEX_LSB];
        end
    end

endmodule

// ==== logic/color_palette.sv ====
/*
 * Sixteen-entry writable YUV palette with a registered lookup.
 * Loads the default colour set at reset. The valid and frame-start flags
 * pass through one register stage so they stay aligned with the colour.
 */

`timescale 1ns/1ps

module color_palette (
    input  logic clock_in,
    input  logic reset_n_in,
    display_write_if.palette writes,
    input  display_pkg::palette_index_t pixel_index,
    input  logic index_valid,
    input  logic index_first,
    output display_pkg::color_t pixel_color,
    output logic pixel_valid,
    output logic frame_start
);

    display_pkg::color_t color_table [display_pkg::PALETTE_SIZE];

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            color_table <= display_pkg::DEFAULT_PALETTE;
            pixel_color <= display_pkg::VOID_COLOR;
        end else if (writes.palette_write) begin
            color_table[writes.palette_index] <= writes.palette_color;

            // The table port is busy with the write, so this pixel goes out black.
            pixel_color <= display_pkg::VOID_COLOR;
        end else begin
            pixel_color <= color_table[pixel_index];
        end
    end

    // Second stage of the flag delay; the scanner provides the first.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pixel_valid <= index_valid;
            frame_start <= index_first;
        end
    end

endmodule

// ==== logic/frame_buffer.sv ====
/*
 * Frame memory of palette indices, one per pixel, in row-major order.
 * Written from the command decoder through the write bus and read by the
 * raster scanner with one cycle of latency.
 */

`timescale 1ns/1ps

module frame_buffer #(
    parameter int FRAME_WIDTH = 16,
    parameter int FRAME_HEIGHT = 16
) (
    input  logic clock_in,
    display_write_if.buffer writes,
    input  logic [((FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                  $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1)-1:0] read_address,
    output display_pkg::palette_index_t read_index
);

    localparam int PIXEL_COUNT = FRAME_WIDTH * FRAME_HEIGHT;

    display_pkg::palette_index_t memory [PIXEL_COUNT];

    // Power-up contents are all index zero, which is the void colour.
    initial begin
        for (int i = 0; i < PIXEL_COUNT; i++) begin
            memory[i] = '0;
        end
    end

    always_ff @(posedge clock_in) begin
        if (writes.pixel_write) begin
            memory[writes.pixel_address] <= writes.pixel_index;
        end
    end

    // A read of the address being written sees the old index.
    always_ff @(posedge clock_in) begin
        read_index <= memory[read_address];
    end

endmodule

// ==== logic/raster_scanner.sv ====
/*
 * Row-major raster scan over the frame buffer.
 * While scanning is enabled it issues one read address per cycle and
 * registers the matching valid and first-pixel flags.
 */

`timescale 1ns/1ps

module raster_scanner #(
    parameter int FRAME_WIDTH = 16,
    parameter int FRAME_HEIGHT = 16
) (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic scan_enable,
    output logic [((FRAME_WIDTH * FRAME_HEIGHT > 1) ?
                  $clog2(FRAME_WIDTH * FRAME_HEIGHT) : 1)-1:0] read_address,
    output logic index_valid,
    output logic index_first
);

    localparam int PIXEL_COUNT = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int ADDRESS_BITS = (PIXEL_COUNT > 1) ? $clog2(PIXEL_COUNT) : 1;
    localparam int COLUMN_BITS = (FRAME_WIDTH > 1) ? $clog2(FRAME_WIDTH) : 1;
    localparam int ROW_BITS = (FRAME_HEIGHT > 1) ? $clog2(FRAME_HEIGHT) : 1;
    localparam logic [COLUMN_BITS-1:0] LAST_COLUMN = COLUMN_BITS'(FRAME_WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(FRAME_HEIGHT - 1);

    typedef enum logic {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_e;

    scan_state_e state;
    logic [COLUMN_BITS-1:0] column;
    logic [ROW_BITS-1:0] row;
    logic issue;

    // An address goes out only while running and still enabled.
    assign issue = (state == SCAN_RUN) && scan_enable;
    assign read_address = ADDRESS_BITS'(row * FRAME_WIDTH + column);

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            state <= SCAN_IDLE;
            column <= '0;
            row <= '0;
        end else if (issue) begin
            if (column == LAST_COLUMN) begin
                column <= '0;
                row <= (row == LAST_ROW) ? '0 : row + 1'b1;
            end else begin
                column <= column + 1'b1;
            end
        end else begin
            // A restart always begins again at the top-left pixel.
            state <= scan_enable ? SCAN_RUN : SCAN_IDLE;
            column <= '0;
            row <= '0;
        end
    end

    // These line up with the index coming back from the frame buffer.
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            index_valid <= 1'b0;
            index_first <= 1'b0;
        end else begin
            index_valid <= issue;
            index_first <= issue && (column == '0) && (row == '0);
        end
    end

endmodule

// ==== logic/display_top.sv ====
/*
 * Top level of the palette display pipeline.
 * Commands enter on the req/ack port; colours leave one per cycle with a
 * valid flag and a frame-start marker while the scan is running.
 */

`timescale 1ns/1ps

module display_top #(
    parameter int FRAME_WIDTH = 16,
    parameter int FRAME_HEIGHT = 16
) (
    input  logic clock_in,
    input  logic reset_n_in,
    input  logic cmd_req,
    input  logic [2:0] cmd_opcode,
    input  logic [command_pkg::CMD_DATA_BITS-1:0] cmd_data,
    output logic cmd_ack,
    output logic pixel_valid,
    output logic frame_start,
    output logic [9:0] pixel_color
);

    localparam int PIXEL_COUNT = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int ADDRESS_BITS = (PIXEL_COUNT > 1) ? $clog2(PIXEL_COUNT) : 1;

    logic scan_enable;
    logic [ADDRESS_BITS-1:0] read_address;
    logic index_valid;
    logic index_first;
    display_pkg::palette_index_t read_index;

    display_write_if #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) write_bus ();

    command_decoder #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) command_decoder_inst (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .cmd_req    (cmd_req),
        .cmd_opcode (command_pkg::cmd_opcode_e'(cmd_opcode)),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack),
        .scan_enable(scan_enable),
        .writes     (write_bus.decoder)
    );

    raster_scanner #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) raster_scanner_inst (
        .clock_in    (clock_in),
        .reset_n_in  (reset_n_in),
        .scan_enable (scan_enable),
        .read_address(read_address),
        .index_valid (index_valid),
        .index_first (index_first)
    );

    frame_buffer #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) frame_buffer_inst (
        .clock_in    (clock_in),
        .writes      (write_bus.buffer),
        .read_address(read_address),
        .read_index  (read_index)
    );

    color_palette color_palette_inst (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .writes     (write_bus.palette),
        .pixel_index(read_index),
        .index_valid(index_valid),
        .index_first(index_first),
        .pixel_color(pixel_color),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start)
    );

endmodule

// ==== dv/display_tb.sv ====
/*
 * Testbench for the palette display pipeline.
 * Sends random commands over the req/ack port, keeps a model of the palette
 * and the frame buffer, and checks every scanned pixel against that model.
 */

`timescale 1ns/1ps

module display_tb;

    localparam int FRAME_WIDTH = 16;
    localparam int FRAME_HEIGHT = 16;
    localparam int PIXELS = FRAME_WIDTH * FRAME_HEIGHT;
    localparam int CLOCK_PERIOD = 40;
    localparam int PALETTE_LOADS = 12;
    localparam int FRAME_WRITES = 48;
    localparam int ACK_LIMIT = 8;
    localparam int IDLE_CHECK_CYCLES = 20;
    localparam int STOP_AFTER_PIXELS = 100;
    // Every command and every scanned frame gets one item's worth of cycles.
    localparam int COMMAND_COUNT = PIXELS + PALETTE_LOADS + FRAME_WRITES + 10;
    localparam int FRAME_COUNT = 6;
    localparam int ITEM_CYCLES = PIXELS + 64;
    localparam int WATCHDOG_NS = (COMMAND_COUNT + FRAME_COUNT) * ITEM_CYCLES * CLOCK_PERIOD;

    logic clock_in;
    logic reset_n_in;
    logic cmd_req;
    logic [2:0] cmd_opcode;
    logic [15:0] cmd_data;
    logic cmd_ack;
    logic pixel_valid;
    logic frame_start;
    logic [9:0] pixel_color;

    display_pkg::color_t palette_model [display_pkg::PALETTE_SIZE];
    display_pkg::palette_index_t frame_model [PIXELS];
    int position;
    int pixels_seen;
    int frames_done;
    logic expect_new_frame;
    logic ack_before;

    display_top #(
        .FRAME_WIDTH (FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT)
    ) display_top_inst (
        .clock_in   (clock_in),
        .reset_n_in (reset_n_in),
        .cmd_req    (cmd_req),
        .cmd_opcode (cmd_opcode),
        .cmd_data   (cmd_data),
        .cmd_ack    (cmd_ack),
        .pixel_valid(pixel_valid),
        .frame_start(frame_start),
        .pixel_color(pixel_color)
    );

    initial begin
        clock_in = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_in = ~clock_in;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
            abort_run();
        end
    endtask

    // Mirrors the effect of one acknowledged command on the model.
    task automatic apply_command(input command_pkg::cmd_opcode_e opcode, input logic [15:0] data);
        int address;
        address = int'(data[command_pkg::PIXEL_ADDRESS_MSB:command_pkg::PIXEL_ADDRESS_LSB]);
        case (opcode)
            command_pkg::CMD_SET_COLOR: begin
                palette_model[data[command_pkg::COLOR_INDEX_MSB:command_pkg::COLOR_INDEX_LSB]] =
                    data[command_pkg::COLOR_VALUE_MSB:command_pkg::COLOR_VALUE_LSB];
            end
            command_pkg::CMD_SET_PIXEL: begin
                if (address < PIXELS) begin
                    frame_model[address] =
                        data[command_pkg::PIXEL_INDEX_MSB:command_pkg::PIXEL_INDEX_LSB];
                end
            end
            command_pkg::CMD_SCAN_START: expect_new_frame = 1'b1;
            default: begin
            end
        endcase
    endtask

    // Full four-phase handshake for one command.
    task automatic send_command(input command_pkg::cmd_opcode_e opcode, input logic [15:0] data);
        int waited;
        @(posedge clock_in);
        cmd_req <= 1'b1;
        cmd_opcode <= opcode;
        cmd_data <= data;
        waited = 0;
        do begin
            @(negedge clock_in);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("No acknowledge arrived for opcode %0d", opcode);
                abort_run();
            end
        end while (cmd_ack !== 1'b1);
        apply_command(opcode, data);
        @(posedge clock_in);
        cmd_req <= 1'b0;
        waited = 0;
        do begin
            @(negedge clock_in);
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("cmd_ack did not fall after the request was released");
                abort_run();
            end
        end while (cmd_ack !== 1'b0);
    endtask

    // The two pixels in flight may still show, then the output must stay quiet.
    task automatic wait_for_idle();
        int waited;
        waited = 0;
        while (pixel_valid !== 1'b0) begin
            @(negedge clock_in);
            waited++;
            if (waited > 4) begin
                $display("pixel_valid stayed high after the scan was stopped");
                abort_run();
            end
        end
        repeat (IDLE_CHECK_CYCLES) begin
            @(negedge clock_in);
            check_value("pixel_valid", 32'd0, 32'(pixel_valid));
        end
    endtask

    task automatic scan_frames(input int count);
        int target;
        target = frames_done + count;
        send_command(command_pkg::CMD_SCAN_START, 16'h0000);
        wait (frames_done >= target);
        send_command(command_pkg::CMD_SCAN_STOP, 16'h0000);
        wait_for_idle();
    endtask

    task automatic load_random_colors();
        logic [3:0] index;
        logic [9:0] color;
        for (int i = 0; i < PALETTE_LOADS; i++) begin
            index = 4'($urandom_range(15, 0));
            color = 10'($urandom_range(1023, 0));
            send_command(command_pkg::CMD_SET_COLOR, {2'b00, index, color});
        end
    endtask

    // Every fourth write aims outside the frame and must be dropped.
    task automatic write_random_pixels();
        logic [11:0] address;
        logic [3:0] index;
        for (int i = 0; i < FRAME_WRITES; i++) begin
            if (i % 4 == 0) begin
                address = 12'($urandom_range(4095, PIXELS));
            end else begin
                address = 12'($urandom_range(PIXELS - 1, 0));
            end
            index = 4'($urandom_range(15, 0));
            send_command(command_pkg::CMD_SET_PIXEL, {address, index});
        end
    endtask

    task automatic stop_and_restart();
        int start_count;
        start_count = pixels_seen;
        send_command(command_pkg::CMD_SCAN_START, 16'h0000);
        wait (pixels_seen >= start_count + STOP_AFTER_PIXELS);
        send_command(command_pkg::CMD_SCAN_STOP, 16'h0000);
        wait_for_idle();
        // The monitor expects address 0 with frame_start on the next valid pixel.
        scan_frames(1);
    endtask

    // Pixel and handshake monitor, sampled away from the driving edge.
    always @(negedge clock_in) begin
        if (reset_n_in) begin
            if (cmd_ack && !ack_before && !cmd_req) begin
                $display("cmd_ack rose without a request at time %0t", $time);
                abort_run();
            end
            if (!cmd_ack && ack_before && cmd_req) begin
                $display("cmd_ack fell while cmd_req was still high at time %0t", $time);
                abort_run();
            end
            ack_before = cmd_ack;
            if (pixel_valid) begin
                if (expect_new_frame) begin
                    position = 0;
                    expect_new_frame = 1'b0;
                end
                check_value("frame_start", 32'(position == 0), 32'(frame_start));
                check_value("pixel_color", 32'(palette_model[frame_model[position]]),
                            32'(pixel_color));
                pixels_seen++;
                if (position == PIXELS - 1) begin
                    position = 0;
                    frames_done++;
                end else begin
                    position++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in the expected time");
        abort_run();
    end

    initial begin
        reset_n_in = 1'b0;
        cmd_req = 1'b0;
        cmd_opcode = 3'd0;
        cmd_data = 16'h0000;
        position = 0;
        pixels_seen = 0;
        frames_done = 0;
        expect_new_frame = 1'b0;
        ack_before = 1'b0;
        palette_model = display_pkg::DEFAULT_PALETTE;
        for (int i = 0; i < PIXELS; i++) begin
            frame_model[i] = '0;
        end
        void'($urandom(32'h33d8cf5d));

        repeat (4) @(posedge clock_in);
        reset_n_in <= 1'b1;
        @(negedge clock_in);
        check_value("cmd_ack", 32'd0, 32'(cmd_ack));
        check_value("pixel_valid", 32'd0, 32'(pixel_valid));
        check_value("frame_start", 32'd0, 32'(frame_start));

        // Default palette in order across the frame.
        for (int i = 0; i < PIXELS; i++) begin
            send_command(command_pkg::CMD_SET_PIXEL, {12'(i), 4'(i % 16)});
        end
        scan_frames(1);

        load_random_colors();
        scan_frames(1);

        write_random_pixels();
        scan_frames(2);

        stop_and_restart();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/display_pkg.sv
logic/command_pkg.sv
logic/display_write_if.sv
logic/command_decoder.sv
logic/color_palette.sv
logic/frame_buffer.sv
logic/raster_scanner.sv
logic/display_top.sv
dv/display_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the palette display testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
    --top-module display_tb \
    --Mdir obj_dir \
    -f filelist.f

# The log decides the result, so a failing run must not stop the script here.
./obj_dir/Vdisplay_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
